// ==== logic/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

`define VADDR_W      32
`define PADDR_W      16
`define PAGE_BITS    12
`define LINE_BYTES   16
`define LINE_OFF_W   4                                // byte offset within a line
`define LINE_W       (`LINE_BYTES * 8)
`define LADDR_W      (`VADDR_W - `LINE_OFF_W)         // virtual line address
`define VPN_W        (`VADDR_W - `PAGE_BITS)
`define PFN_W        (`PADDR_W - `PAGE_BITS)
`define PGLINE_W     (`PAGE_BITS - `LINE_OFF_W)       // line bits inside a page
`define PLINE_W      (`PADDR_W - `LINE_OFF_W)         // physical line address

// bit 0 of the line address picks the bank
`define ICACHE_SETS  16
`define INDEX_W      4
`define TAG_W        (`PLINE_W - `INDEX_W - 1)

`define TLB_ENTRIES  8
`define TLB_IDX_W    3

`define APB_DATA_W   32
`define BEATS        (`LINE_W / `APB_DATA_W)
`define BEAT_W       2

`endif

// ==== logic/fetch_pkg.sv ====
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_TLB_MISS,
        FAULT_NOT_PRESENT
    } fault_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_FILL_EVEN,
        ST_FILL_ODD,
        ST_INSTALL
    } fill_state_e;

    typedef struct packed {
        logic                valid;
        logic [`LADDR_W-1:0] line;     // target line, vaddr[31:4]
    } redirect_t;

    typedef struct packed {
        logic              valid;
        logic              present;
        logic [`VPN_W-1:0] vpn;
        logic [`PFN_W-1:0] pfn;
    } tlb_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`TLB_IDX_W-1:0] idx;
        tlb_entry_t            entry;
    } tlb_wr_t;

    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        fault_e            fault;
    } tlb_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [`INDEX_W-1:0] index;
        logic [`TAG_W-1:0]   tag;
        logic [`LINE_W-1:0]  line;
    } fill_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`PADDR_W-1:0]    paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    // line_first sits at line_addr, line_second at line_addr + 1
    typedef struct packed {
        logic                valid;
        logic [`LADDR_W-1:0] line_addr;
        logic [`LINE_W-1:0]  line_first;
        logic [`LINE_W-1:0]  line_second;
        fault_e              fault_even;
        fault_e              fault_odd;
    } fetch_bundle_t;

endpackage

`default_nettype wire

// ==== logic/fip_select.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fip_select (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  fetch_pkg::redirect_t init_i,
    input  fetch_pkg::redirect_t resteer_i,
    input  fetch_pkg::redirect_t branch_i,
    input  wire                  advance_i,
    output logic [`LADDR_W-1:0]  line_even_o,
    output logic [`LADDR_W-1:0]  line_odd_o,
    output logic                 armed_o
);

    logic                redirect;
    logic [`LADDR_W-1:0] target;
    logic [`LADDR_W-1:0] target_next;

    // init wins over resteer, resteer over branch
    always_comb begin
        redirect = init_i.valid | resteer_i.valid | branch_i.valid;
        if (init_i.valid) begin
            target = init_i.line;
        end else if (resteer_i.valid) begin
            target = resteer_i.line;
        end else begin
            target = branch_i.line;
        end
        target_next = target + 1'b1;
    end

    //////////////////////////////////////////////////
    // pointer registers

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_even_o <= '0;
            line_odd_o  <= '0;
            armed_o     <= 1'b0;
        end else if (redirect) begin    // redirect beats advance
            line_even_o <= target[0] ? target_next : target;
            line_odd_o  <= target[0] ? target : target_next;
            armed_o     <= 1'b1;
        end else if (advance_i) begin
            line_even_o <= line_even_o + 2'd2;
            line_odd_o  <= line_odd_o + 2'd2;
        end
    end

    // once armed the two pointers stay adjacent with fixed parity
    a_ptr_parity: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        armed_o |-> (!line_even_o[0] && line_odd_o[0] &&
                     (line_even_o == line_odd_o + 1'b1 || line_odd_o == line_even_o + 1'b1))
    );

endmodule

`default_nettype wire

// ==== logic/itlb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module itlb (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  fetch_pkg::tlb_wr_t    tlb_wr_i,
    input  wire  [`LADDR_W-1:0]   lkp_even_i,
    input  wire  [`LADDR_W-1:0]   lkp_odd_i,
    output fetch_pkg::tlb_rsp_t   rsp_even_o,
    output fetch_pkg::tlb_rsp_t   rsp_odd_o
);

    fetch_pkg::tlb_entry_t    entries_q [`TLB_ENTRIES];
    logic [`VPN_W-1:0]        vpn       [2];    // port 0 even, port 1 odd
    logic [`TLB_ENTRIES-1:0]  match     [2];
    logic [1:0]               present;
    fetch_pkg::tlb_rsp_t      rsp       [2];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries_q[i] <= '0;
            end
        end else if (tlb_wr_i.valid) begin
            entries_q[tlb_wr_i.idx] <= tlb_wr_i.entry;
        end
    end

    assign vpn[0] = lkp_even_i[`LADDR_W-1:`PGLINE_W];
    assign vpn[1] = lkp_odd_i[`LADDR_W-1:`PGLINE_W];

    //////////////////////////////////////////////////
    // fully associative compare, both ports

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            match[p]   = '0;
            present[p] = 1'b0;
            rsp[p].pfn = '0;
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (entries_q[i].valid && entries_q[i].vpn == vpn[p]) begin
                    match[p][i] = 1'b1;
                    present[p]  = present[p] | entries_q[i].present;
                    rsp[p].pfn  = rsp[p].pfn | entries_q[i].pfn;
                end
            end
            if (match[p] == '0) begin
                rsp[p].fault = fetch_pkg::FAULT_TLB_MISS;
            end else if (!present[p]) begin
                rsp[p].fault = fetch_pkg::FAULT_NOT_PRESENT;
            end else begin
                rsp[p].fault = fetch_pkg::FAULT_NONE;
            end
        end
    end

    assign rsp_even_o = rsp[0];
    assign rsp_odd_o  = rsp[1];

    // loader must never leave two entries for one page
    a_one_match: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(match[0]) && $onehot0(match[1])
    );

endmodule

`default_nettype wire

// ==== logic/icache_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module icache_bank (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire [`INDEX_W-1:0]  index_i,
    input  wire [`TAG_W-1:0]    tag_i,      // pfn plus line bits above the index
    input  fetch_pkg::fill_t    fill_i,
    output logic                hit_o,
    output logic [`LINE_W-1:0]  line_o
);

    logic [`ICACHE_SETS-1:0] valid_q;
    logic [`TAG_W-1:0]       tags_q  [`ICACHE_SETS];
    logic [`LINE_W-1:0]      lines_q [`ICACHE_SETS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i.valid) begin
            valid_q[fill_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i.valid) begin
            tags_q[fill_i.index]  <= fill_i.tag;
            lines_q[fill_i.index] <= fill_i.line;
        end
    end

    //////////////////////////////////////////////////
    // virtually indexed, physically tagged lookup

    assign hit_o  = valid_q[index_i] && (tags_q[index_i] == tag_i);
    assign line_o = lines_q[index_i];

    // the controller latches its fill address at miss time
    a_fill_index_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        fill_i.valid |-> !$isunknown(fill_i.index)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      armed_i,
    input  wire  [`LADDR_W-1:0]      line_even_i,
    input  wire  [`LADDR_W-1:0]      line_odd_i,
    input  fetch_pkg::tlb_rsp_t      rsp_even_i,
    input  fetch_pkg::tlb_rsp_t      rsp_odd_i,
    input  wire                      hit_even_i,
    input  wire                      hit_odd_i,
    input  wire  [`LINE_W-1:0]       data_even_i,
    input  wire  [`LINE_W-1:0]       data_odd_i,
    input  wire                      bundle_ready_i,
    input  fetch_pkg::apb_rsp_t      apb_i,
    output logic                     advance_o,
    output fetch_pkg::fill_t         fill_even_o,
    output fetch_pkg::fill_t         fill_odd_o,
    output fetch_pkg::fetch_bundle_t bundle_o,
    output fetch_pkg::apb_req_t      apb_o
);

    fetch_pkg::fill_state_e state_q;
    logic                   need_even_q;
    logic                   need_odd_q;
    logic [`BEAT_W-1:0]     beat_q;
    logic                   psel_q;
    logic                   penable_q;
    logic [`PLINE_W-1:0]    pla_even_q;    // physical line of each pending fill
    logic [`PLINE_W-1:0]    pla_odd_q;
    logic [`PLINE_W-1:0]    pla_cur;
    logic [`LINE_W-1:0]     buf_even_q;
    logic [`LINE_W-1:0]     buf_odd_q;

    logic bad_even;
    logic bad_odd;
    logic miss_even;
    logic miss_odd;
    logic first_is_odd;
    logic start_fill;
    logic beat_done;

    assign bad_even     = rsp_even_i.fault != fetch_pkg::FAULT_NONE;
    assign bad_odd      = rsp_odd_i.fault != fetch_pkg::FAULT_NONE;
    assign miss_even    = !hit_even_i && !bad_even;   // faulting bank is never filled
    assign miss_odd     = !hit_odd_i && !bad_odd;
    assign first_is_odd = line_even_i == line_odd_i + 1'b1;
    assign start_fill   = armed_i && state_q == fetch_pkg::ST_RUN && (miss_even || miss_odd);
    assign beat_done    = psel_q && penable_q && apb_i.pready;

    //////////////////////////////////////////////////
    // bundle side

    always_comb begin
        bundle_o.valid       = armed_i && state_q == fetch_pkg::ST_RUN && !miss_even && !miss_odd;
        bundle_o.line_addr   = first_is_odd ? line_odd_i : line_even_i;
        bundle_o.line_first  = first_is_odd ? (bad_odd ? '0 : data_odd_i)
                                            : (bad_even ? '0 : data_even_i);
        bundle_o.line_second = first_is_odd ? (bad_even ? '0 : data_even_i)
                                            : (bad_odd ? '0 : data_odd_i);
        bundle_o.fault_even  = rsp_even_i.fault;
        bundle_o.fault_odd   = rsp_odd_i.fault;
    end

    // a faulty pair is handed out but the pointer stays put
    assign advance_o = bundle_o.valid && bundle_ready_i && !bad_even && !bad_odd;

    //////////////////////////////////////////////////
    // fill FSM and APB master

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= fetch_pkg::ST_RUN;
            need_even_q <= 1'b0;
            need_odd_q  <= 1'b0;
            beat_q      <= '0;
            psel_q      <= 1'b0;
            penable_q   <= 1'b0;
        end else begin
            case (state_q)
                fetch_pkg::ST_RUN: begin
                    if (start_fill) begin
                        need_even_q <= miss_even;
                        need_odd_q  <= miss_odd;
                        state_q     <= miss_even ? fetch_pkg::ST_FILL_EVEN
                                                 : fetch_pkg::ST_FILL_ODD;
                        beat_q      <= '0;
                        psel_q      <= 1'b1;    // setup cycle
                        penable_q   <= 1'b0;
                    end
                end
                fetch_pkg::ST_FILL_EVEN, fetch_pkg::ST_FILL_ODD: begin
                    if (!penable_q) begin
                        penable_q <= 1'b1;
                    end else if (apb_i.pready) begin
                        penable_q <= 1'b0;
                        beat_q    <= beat_q + 1'b1;
                        if (beat_q == `BEAT_W'(`BEATS - 1)) begin
                            if (state_q == fetch_pkg::ST_FILL_EVEN && need_odd_q) begin
                                state_q <= fetch_pkg::ST_FILL_ODD;
                            end else begin
                                state_q <= fetch_pkg::ST_INSTALL;
                                psel_q  <= 1'b0;
                            end
                        end
                    end
                end
                default: begin    // install writes the lines this cycle
                    state_q <= fetch_pkg::ST_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_fill) begin
            pla_even_q <= {rsp_even_i.pfn, line_even_i[`PGLINE_W-1:0]};
            pla_odd_q  <= {rsp_odd_i.pfn, line_odd_i[`PGLINE_W-1:0]};
        end
        if (beat_done) begin
            // lowest word arrives first and ends at the bottom
            if (state_q == fetch_pkg::ST_FILL_EVEN) begin
                buf_even_q <= {apb_i.prdata, buf_even_q[`LINE_W-1:`APB_DATA_W]};
            end else begin
                buf_odd_q <= {apb_i.prdata, buf_odd_q[`LINE_W-1:`APB_DATA_W]};
            end
        end
    end

    assign pla_cur = (state_q == fetch_pkg::ST_FILL_ODD) ? pla_odd_q : pla_even_q;

    always_comb begin
        apb_o.psel    = psel_q;
        apb_o.penable = penable_q;
        apb_o.pwrite  = 1'b0;
        apb_o.paddr   = {pla_cur, beat_q, 2'b00};
        apb_o.pwdata  = '0;
    end

    always_comb begin
        fill_even_o.valid = state_q == fetch_pkg::ST_INSTALL && need_even_q;
        fill_even_o.index = pla_even_q[`INDEX_W:1];
        fill_even_o.tag   = pla_even_q[`PLINE_W-1:`INDEX_W+1];
        fill_even_o.line  = buf_even_q;
        fill_odd_o.valid  = state_q == fetch_pkg::ST_INSTALL && need_odd_q;
        fill_odd_o.index  = pla_odd_q[`INDEX_W:1];
        fill_odd_o.tag    = pla_odd_q[`PLINE_W-1:`INDEX_W+1];
        fill_odd_o.line   = buf_odd_q;
    end

    a_penable_after_setup: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(apb_o.penable) |-> apb_o.psel && $past(apb_o.psel)
    );

    a_no_psel_in_run: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        state_q == fetch_pkg::ST_RUN |-> !apb_o.psel
    );

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  fetch_pkg::redirect_t     init_i,
    input  fetch_pkg::redirect_t     resteer_i,
    input  fetch_pkg::redirect_t     branch_i,
    input  fetch_pkg::tlb_wr_t       tlb_wr_i,
    output fetch_pkg::fetch_bundle_t bundle_o,
    input  wire                      bundle_ready_i,
    output fetch_pkg::apb_req_t      apb_o,
    input  fetch_pkg::apb_rsp_t      apb_i
);

    logic [`LADDR_W-1:0] line_even;
    logic [`LADDR_W-1:0] line_odd;
    logic                armed;
    logic                advance;
    fetch_pkg::tlb_rsp_t rsp_even;
    fetch_pkg::tlb_rsp_t rsp_odd;
    logic                hit_even;
    logic                hit_odd;
    logic [`LINE_W-1:0]  data_even;
    logic [`LINE_W-1:0]  data_odd;
    fetch_pkg::fill_t    fill_even;
    fetch_pkg::fill_t    fill_odd;

    fip_select i_fip_select (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .init_i      (init_i),
        .resteer_i   (resteer_i),
        .branch_i    (branch_i),
        .advance_i   (advance),
        .line_even_o (line_even),
        .line_odd_o  (line_odd),
        .armed_o     (armed)
    );

    itlb i_itlb (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .tlb_wr_i   (tlb_wr_i),
        .lkp_even_i (line_even),
        .lkp_odd_i  (line_odd),
        .rsp_even_o (rsp_even),
        .rsp_odd_o  (rsp_odd)
    );

    //////////////////////////////////////////////////
    // banks take the index from vaddr and the tag from the frame

    icache_bank i_bank_even (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .index_i (line_even[`INDEX_W:1]),
        .tag_i   ({rsp_even.pfn, line_even[`PGLINE_W-1:`INDEX_W+1]}),
        .fill_i  (fill_even),
        .hit_o   (hit_even),
        .line_o  (data_even)
    );

    icache_bank i_bank_odd (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .index_i (line_odd[`INDEX_W:1]),
        .tag_i   ({rsp_odd.pfn, line_odd[`PGLINE_W-1:`INDEX_W+1]}),
        .fill_i  (fill_odd),
        .hit_o   (hit_odd),
        .line_o  (data_odd)
    );

    fetch_ctrl i_fetch_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .armed_i        (armed),
        .line_even_i    (line_even),
        .line_odd_i     (line_odd),
        .rsp_even_i     (rsp_even),
        .rsp_odd_i      (rsp_odd),
        .hit_even_i     (hit_even),
        .hit_odd_i      (hit_odd),
        .data_even_i    (data_even),
        .data_odd_i     (data_odd),
        .bundle_ready_i (bundle_ready_i),
        .apb_i          (apb_i),
        .advance_o      (advance),
        .fill_even_o    (fill_even),
        .fill_odd_o     (fill_odd),
        .bundle_o       (bundle_o),
        .apb_o          (apb_o)
    );

endmodule

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    localparam int            N_ROWS         = 15;
    localparam int            FILL_CYCLES    = 2 * `BEATS * 4 + 2;  // two banks at 4 cycles a beat
    localparam int            TIMEOUT_CYCLES = N_ROWS * FILL_CYCLES * 2;
    localparam logic [15:0]   MEM_KEY        = 16'hc3a5;

    typedef logic [`LINE_W-1:0] wide_t;

    // a row holds a TLB load or a redirect with its expected bundles
    typedef struct packed {
        logic                 is_fetch;
        fetch_pkg::tlb_wr_t   tlb_wr;
        fetch_pkg::redirect_t init;
        fetch_pkg::redirect_t resteer;
        fetch_pkg::redirect_t branch;
        logic                 rand_ready;
        logic [3:0]           n_accept;    // one more bundle is observed, not taken
        logic [`LADDR_W-1:0]  exp_line;
        fetch_pkg::fault_e    exp_fault_even;
        fetch_pkg::fault_e    exp_fault_odd;
        logic [7:0]           exp_apb;
    } row_t;

    logic                     clk = 1'b0;
    logic                     rst_n;
    fetch_pkg::redirect_t     redir_init;
    fetch_pkg::redirect_t     redir_resteer;
    fetch_pkg::redirect_t     redir_branch;
    fetch_pkg::tlb_wr_t       tlb_wr;
    fetch_pkg::fetch_bundle_t bundle;
    logic                     bundle_ready;
    fetch_pkg::apb_req_t      apb_req;
    fetch_pkg::apb_rsp_t      apb_rsp;

    row_t                     rows [N_ROWS];
    logic [`PFN_W-1:0]        pfn_of [logic [`VPN_W-1:0]];   // page map as loaded
    logic [31:0]              rand_state = 32'd91;
    int unsigned              apb_count;
    int                       error_cnt = 0;
    int                       check_cnt = 0;
    logic [1:0]               wait_cnt;
    logic                     wait_two;
    logic [15:0]              setup_addr;

    always #20 clk = ~clk;

    fetch_top i_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .init_i         (redir_init),
        .resteer_i      (redir_resteer),
        .branch_i       (redir_branch),
        .tlb_wr_i       (tlb_wr),
        .bundle_o       (bundle),
        .bundle_ready_i (bundle_ready),
        .apb_o          (apb_req),
        .apb_i          (apb_rsp)
    );

    //////////////////////////////////////////////////
    // memory contents and helpers

    function automatic logic [31:0] mem_word(input logic [15:0] addr);
        return {addr ^ MEM_KEY, addr};
    endfunction

    function automatic wide_t mem_line(input logic [`PLINE_W-1:0] pla);
        wide_t l;
        for (int b = 0; b < `BEATS; b++) begin
            l[b*`APB_DATA_W +: `APB_DATA_W] = mem_word({pla, 2'(b), 2'b00});
        end
        return l;
    endfunction

    function automatic wide_t expected_line(input logic [`LADDR_W-1:0] line,
                                            input fetch_pkg::fault_e f);
        logic [`PLINE_W-1:0] pla;
        if (f != fetch_pkg::FAULT_NONE) begin
            return '0;    // faulting bank delivers zeros
        end
        pla = {pfn_of[line[`LADDR_W-1:`PGLINE_W]], line[`PGLINE_W-1:0]};
        return mem_line(pla);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compare(input string name, input wide_t exp_v, input wide_t act);
        check_cnt++;
        if (act !== exp_v) begin
            error_cnt++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus table

    function automatic row_t cfg_row(input logic [`TLB_IDX_W-1:0] idx,
                                     input logic [`VPN_W-1:0] vpn,
                                     input logic [`PFN_W-1:0] pfn,
                                     input logic present);
        row_t r;
        r = '0;
        r.tlb_wr.valid         = 1'b1;
        r.tlb_wr.idx           = idx;
        r.tlb_wr.entry.valid   = 1'b1;
        r.tlb_wr.entry.present = present;
        r.tlb_wr.entry.vpn     = vpn;
        r.tlb_wr.entry.pfn     = pfn;
        return r;
    endfunction

    // src bits are init, resteer and branch
    function automatic row_t fetch_row(input logic [2:0] src,
                                       input logic [`LADDR_W-1:0] target,
                                       input logic rnd,
                                       input logic [3:0] n,
                                       input fetch_pkg::fault_e fe,
                                       input fetch_pkg::fault_e fo,
                                       input logic [7:0] apb);
        row_t r;
        r = '0;
        r.is_fetch       = 1'b1;
        r.init           = '{valid: src[2], line: target};
        r.resteer        = '{valid: src[1], line: target};
        r.branch         = '{valid: src[0], line: target};
        r.rand_ready     = rnd;
        r.n_accept       = n;
        r.exp_line       = target;
        r.exp_fault_even = fe;
        r.exp_fault_odd  = fo;
        r.exp_apb        = apb;
        return r;
    endfunction

    task automatic build_table();
        rows[0]  = cfg_row(3'd0, 20'h00010, 4'h3, 1'b1);
        rows[1]  = cfg_row(3'd1, 20'h00011, 4'h7, 1'b1);
        rows[2]  = cfg_row(3'd2, 20'h00020, 4'h5, 1'b0);
        rows[3]  = cfg_row(3'd3, 20'h00021, 4'h9, 1'b1);
        // odd start gives three cold pairs and then the same lines from cache
        rows[4]  = fetch_row(3'b100, 28'h0001001, 1'b0, 4'd2, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd24);
        rows[5]  = fetch_row(3'b001, 28'h0001001, 1'b0, 4'd2, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd0);
        rows[6]  = fetch_row(3'b111, 28'h0001001, 1'b0, 4'd0, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd0);
        rows[6].resteer.line = 28'h0001003;
        rows[6].branch.line  = 28'h0001005;
        rows[7]  = fetch_row(3'b011, 28'h0001003, 1'b0, 4'd0, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd0);
        rows[7].branch.line  = 28'h0001005;
        rows[8]  = fetch_row(3'b100, 28'h0004000, 1'b0, 4'd2, fetch_pkg::FAULT_TLB_MISS,
                             fetch_pkg::FAULT_TLB_MISS, 8'd0);
        rows[9]  = fetch_row(3'b010, 28'h0002000, 1'b0, 4'd1, fetch_pkg::FAULT_NOT_PRESENT,
                             fetch_pkg::FAULT_NOT_PRESENT, 8'd0);
        // page crossings use two frames through the two TLB ports
        rows[10] = fetch_row(3'b001, 28'h00011ff, 1'b0, 4'd1, fetch_pkg::FAULT_TLB_MISS,
                             fetch_pkg::FAULT_NONE, 8'd4);
        rows[11] = fetch_row(3'b010, 28'h00010ff, 1'b0, 4'd0, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd8);
        rows[12] = fetch_row(3'b100, 28'h00020ff, 1'b0, 4'd1, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NOT_PRESENT, 8'd4);
        rows[13] = fetch_row(3'b001, 28'h0002110, 1'b1, 4'd4, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd40);
        rows[14] = fetch_row(3'b010, 28'h0002110, 1'b1, 4'd4, fetch_pkg::FAULT_NONE,
                             fetch_pkg::FAULT_NONE, 8'd0);
    endtask

    //////////////////////////////////////////////////
    // row application

    task automatic apply_config(input row_t r);
        @(posedge clk);
        tlb_wr <= r.tlb_wr;
        pfn_of[r.tlb_wr.entry.vpn] = r.tlb_wr.entry.pfn;
        @(posedge clk);
        tlb_wr <= '0;
        @(negedge clk);
        // nothing may move before the first redirect
        compare("bundle_o.valid", '0, wide_t'(bundle.valid));
        compare("apb_o.psel", '0, wide_t'(apb_req.psel));
        compare("apb transfers", '0, wide_t'(apb_count));
    endtask

    task automatic check_bundle(input logic [`LADDR_W-1:0] line,
                                input fetch_pkg::fault_e fe,
                                input fetch_pkg::fault_e fo);
        fetch_pkg::fault_e f_first;
        fetch_pkg::fault_e f_second;
        f_first  = line[0] ? fo : fe;
        f_second = line[0] ? fe : fo;
        compare("bundle_o.line_addr", wide_t'(line), wide_t'(bundle.line_addr));
        compare("bundle_o.fault_even", wide_t'(fe), wide_t'(bundle.fault_even));
        compare("bundle_o.fault_odd", wide_t'(fo), wide_t'(bundle.fault_odd));
        compare("bundle_o.line_first", expected_line(line, f_first), bundle.line_first);
        compare("bundle_o.line_second", expected_line(line + 28'd1, f_second),
                bundle.line_second);
    endtask

    task automatic run_fetch_row(input row_t r);
        int unsigned         apb_start;
        logic [3:0]          got;
        logic [`LADDR_W-1:0] exp_line;
        logic                held;
        logic                done;
        logic                ready_next;
        apb_start = apb_count;
        got       = '0;
        exp_line  = r.exp_line;
        held      = 1'b0;
        done      = 1'b0;
        @(posedge clk);
        redir_init    <= r.init;
        redir_resteer <= r.resteer;
        redir_branch  <= r.branch;
        bundle_ready  <= 1'b0;
        @(posedge clk);
        redir_init    <= '0;
        redir_resteer <= '0;
        redir_branch  <= '0;
        while (!done) begin
            if (got < r.n_accept) begin
                rand_state = lcg_next(rand_state);
                ready_next = r.rand_ready ? rand_state[16] : 1'b1;
            end else begin
                ready_next = 1'b0;    // last bundle is only looked at
            end
            bundle_ready <= ready_next;
            @(negedge clk);
            if (bundle.valid) begin
                check_bundle(exp_line, r.exp_fault_even, r.exp_fault_odd);
                if (bundle_ready) begin
                    got  = got + 4'd1;
                    held = 1'b0;
                    if (r.exp_fault_even == fetch_pkg::FAULT_NONE &&
                        r.exp_fault_odd == fetch_pkg::FAULT_NONE) begin
                        exp_line = exp_line + 28'd2;
                    end
                end else if (got == r.n_accept) begin
                    done = 1'b1;
                end else begin
                    held = 1'b1;
                end
            end else if (held) begin
                error_cnt++;
                $display("error at %0t: bundle valid dropped while ready was low", $time);
                held = 1'b0;
            end
            @(posedge clk);
        end
        compare("apb transfers", wide_t'(r.exp_apb), wide_t'(apb_count - apb_start));
    endtask

    //////////////////////////////////////////////////
    // APB memory alternates one and two wait states

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            apb_rsp    <= '0;
            wait_cnt   <= 2'd0;
            wait_two   <= 1'b0;
            apb_count  <= 0;
            setup_addr <= '0;
        end else if (apb_req.psel && !apb_req.penable) begin
            wait_cnt       <= wait_two ? 2'd2 : 2'd1;
            wait_two       <= !wait_two;
            setup_addr     <= apb_req.paddr;
            apb_rsp.pready <= 1'b0;
        end else if (apb_req.psel && apb_req.penable) begin
            if (apb_req.paddr !== setup_addr) begin    // address held through access
                error_cnt++;
                $display("mismatch at %0t: apb_o.paddr expected %h got %h",
                         $time, setup_addr, apb_req.paddr);
            end
            if (apb_rsp.pready) begin    // transfer completes at this edge
                apb_rsp.pready <= 1'b0;
                apb_count      <= apb_count + 1;
            end else if (wait_cnt == 2'd1) begin
                apb_rsp.pready <= 1'b1;
                apb_rsp.prdata <= mem_word(apb_req.paddr);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
        if (rst_n && apb_req.psel && apb_req.pwrite) begin
            error_cnt++;
            $display("error at %0t: APB write issued by a fetch unit", $time);
        end
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        rst_n         <= 1'b0;
        redir_init    <= '0;
        redir_resteer <= '0;
        redir_branch  <= '0;
        tlb_wr        <= '0;
        bundle_ready  <= 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            if (rows[i].is_fetch) begin
                run_fetch_row(rows[i]);
            end else begin
                apply_config(rows[i]);
            end
        end
        $display("summary: %0d checks, %0d errors, %0d apb transfers",
                 check_cnt, error_cnt, apb_count);
        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/fip_select.sv
logic/itlb.sv
logic/icache_bank.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
bench/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
RTL_TOP   ?= fetch_top
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

SRCS      := $(shell grep -v '^+' $(FILELIST)) logic/fetch_macros.svh
LINT_SRCS := $(shell grep -v '^+' $(FILELIST) | grep -v '^bench/')

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+logic $(LINT_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
